// ==== flist.f ====
hw/wb_pkg.sv
hw/board_pkg.sv
hw/serial_uart.sv
hw/as_wb_bridge.sv
hw/wbs_arbiter.sv
hw/sys_block.sv
hw/led_block.sv
hw/toplevel.sv
tb/toplevel_assert.sv
tb/toplevel_tb.sv

// ==== hw/as_wb_bridge.sv ====
`timescale 1ns/100ps

module as_wb_bridge import wb_pkg::*, board_pkg::*; (
  input  logic                    mgt_clk,
  input  logic                    arst_n_i,
  input  logic [7:0]              rx_data_i,
  input  logic                    rx_dstrb_i,
  input  logic                    tx_busy_i,
  output logic [7:0]              tx_data_o,
  output logic                    tx_dstrb_o,
  output logic                    wbm_cyc_o,
  output logic                    wbm_stb_o,
  output logic                    wbm_we_o,
  output wb_addr_u                wbm_adr_o,
  output logic [WB_DATA_BITS-1:0] wbm_wdat_o,
  input  logic [WB_DATA_BITS-1:0] wbm_rdat_i,
  input  logic                    wbm_ack_i,
  input  logic                    wbm_err_i
);

  enum logic [2:0] {ST_CMD, ST_ADR, ST_DAT, ST_BUS, ST_RSP} state;

  logic                    is_write;
  logic [1:0]              byte_cnt;
  logic                    bus_req;
  logic                    rsp_err;
  logic [1:0]              rsp_idx;
  logic                    rsp_last;
  logic [7:0]              rsp_byte;
  logic                    tx_send;
  logic                    bus_done;
  wb_addr_u                adr_q;
  logic [WB_DATA_BITS-1:0] wdat_q;
  logic [WB_DATA_BITS-1:0] rdat_q;

  assign bus_done = (state == ST_BUS) && (wbm_ack_i || wbm_err_i);
  assign tx_send  = (state == ST_RSP) && !tx_busy_i && !tx_dstrb_o;
  assign rsp_last = rsp_err || is_write || rsp_idx == 2'd2;

  always_comb begin
    case (rsp_idx)
      2'd0:    rsp_byte = rsp_err ? RSP_ERR : RSP_OK;
      2'd1:    rsp_byte = rdat_q[15:8];
      default: rsp_byte = rdat_q[7:0];
    endcase
  end

  always_ff @(posedge mgt_clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state      <= ST_CMD;
      is_write   <= 1'b0;
      byte_cnt   <= 2'd0;
      bus_req    <= 1'b0;
      rsp_err    <= 1'b0;
      rsp_idx    <= 2'd0;
      tx_dstrb_o <= 1'b0;
    end else begin
      tx_dstrb_o <= 1'b0;
      case (state)
        ST_CMD: if (rx_dstrb_i) begin
          byte_cnt <= 2'd0;
          if (rx_data_i == CMD_READ || rx_data_i == CMD_WRITE) begin
            is_write <= rx_data_i == CMD_WRITE;
            state    <= ST_ADR;
          end
        end
        ST_ADR: if (rx_dstrb_i) begin
          byte_cnt <= byte_cnt + 1'b1;
          if (byte_cnt == 2'd3) begin
            byte_cnt <= 2'd0;
            state    <= is_write ? ST_DAT : ST_BUS;
            bus_req  <= !is_write;
          end
        end
        ST_DAT: if (rx_dstrb_i) begin
          byte_cnt <= byte_cnt + 1'b1;
          if (byte_cnt == 2'd1) begin
            state   <= ST_BUS;
            bus_req <= 1'b1;
          end
        end
        ST_BUS: if (bus_done) begin
          bus_req <= 1'b0;
          rsp_err <= wbm_err_i;
          rsp_idx <= 2'd0;
          state   <= ST_RSP;
        end
        default: if (tx_send) begin
          tx_dstrb_o <= 1'b1;
          rsp_idx    <= rsp_idx + 1'b1;
          if (rsp_last)
            state <= ST_CMD;
        end
      endcase
    end
  end

  // msb first on both address and data
  always_ff @(posedge mgt_clk) begin
    if (state == ST_ADR && rx_dstrb_i)
      adr_q.raw <= {adr_q.raw[WB_ADDR_BITS-9:0], rx_data_i};
    if (state == ST_DAT && rx_dstrb_i)
      wdat_q <= {wdat_q[7:0], rx_data_i};
    if (bus_done)
      rdat_q <= wbm_rdat_i;
    if (tx_send)
      tx_data_o <= rsp_byte;
  end

  assign wbm_cyc_o  = bus_req;
  assign wbm_stb_o  = bus_req;
  assign wbm_we_o   = is_write;
  assign wbm_adr_o  = adr_q;
  assign wbm_wdat_o = wdat_q;

endmodule

// ==== hw/board_pkg.sv ====
package board_pkg;

  // board identity
  localparam logic [15:0] BOARD_ID  = 16'hb0a2;
  localparam logic [15:0] REV_MAJOR = 16'h0001;
  localparam logic [15:0] REV_MINOR = 16'h0004;
  localparam logic [15:0] REV_RCS   = 16'h02c7;

  // serial timing
  localparam int UART_CLKS_PER_BIT = 16;
  localparam int UART_CNT_BITS     = $clog2(UART_CLKS_PER_BIT);
  localparam logic [UART_CNT_BITS-1:0] UART_BIT_LAST  = UART_CNT_BITS'(UART_CLKS_PER_BIT - 1);
  localparam logic [UART_CNT_BITS-1:0] UART_HALF_LAST = UART_CNT_BITS'(UART_CLKS_PER_BIT / 2 - 1);

  // host protocol
  localparam logic [7:0] CMD_READ  = 8'h01;
  localparam logic [7:0] CMD_WRITE = 8'h02;
  localparam logic [7:0] RSP_OK    = 8'h00;
  localparam logic [7:0] RSP_ERR   = 8'hFF;

  // system block register offsets
  localparam logic [15:0] SYS_REG_ID      = 16'd0;
  localparam logic [15:0] SYS_REG_MAJOR   = 16'd1;
  localparam logic [15:0] SYS_REG_MINOR   = 16'd2;
  localparam logic [15:0] SYS_REG_RCS     = 16'd3;
  localparam logic [15:0] SYS_REG_SCRATCH = 16'd4;

endpackage

// ==== hw/led_block.sv ====
`timescale 1ns/100ps

module led_block import wb_pkg::*; (
  input  logic                    mgt_clk,
  input  logic                    arst_n_i,
  input  logic                    wb_cyc_i,
  input  logic                    wb_stb_i,
  input  logic                    wb_we_i,
  input  wb_addr_u                wb_adr_i,
  input  logic [WB_DATA_BITS-1:0] wb_dat_i,
  output logic [WB_DATA_BITS-1:0] wb_dat_o,
  output logic                    wb_ack_o,
  output logic [7:0]              led_n_o
);

  logic       req;
  logic [7:0] led_reg;

  assign req = wb_cyc_i && wb_stb_i && !wb_ack_o;

  always_ff @(posedge mgt_clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wb_ack_o <= 1'b0;
      led_reg  <= 8'h00;
    end else begin
      wb_ack_o <= req;
      if (req && wb_we_i) // any offset
        led_reg <= wb_dat_i[7:0];
    end
  end

  assign wb_dat_o = {{(WB_DATA_BITS-8){1'b0}}, led_reg};
  assign led_n_o  = ~led_reg; // pins are active low

endmodule

// ==== hw/serial_uart.sv ====
`timescale 1ns/100ps

module serial_uart import board_pkg::*; (
  input  logic       mgt_clk,
  input  logic       arst_n_i,
  input  logic       serial_i,
  input  logic [7:0] tx_data_i,
  input  logic       tx_dstrb_i,
  output logic [7:0] rx_data_o,
  output logic       rx_dstrb_o,
  output logic       tx_busy_o,
  output logic       serial_o
);

  logic [1:0]               rx_sync;
  logic                     rx_in;
  logic                     rx_active;
  logic [3:0]               rx_bitn;   // 0 start, 1..8 data, 9 stop
  logic [UART_CNT_BITS-1:0] rx_cnt;
  logic [7:0]               rx_shift;

  logic [9:0]               tx_shift;
  logic [3:0]               tx_bits;
  logic [UART_CNT_BITS-1:0] tx_cnt;

  assign rx_in = rx_sync[1];

  always_ff @(posedge mgt_clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rx_sync    <= 2'b11;
      rx_active  <= 1'b0;
      rx_bitn    <= 4'd0;
      rx_cnt     <= '0;
      rx_dstrb_o <= 1'b0;
    end else begin
      rx_sync    <= {rx_sync[0], serial_i};
      rx_dstrb_o <= 1'b0;
      if (!rx_active) begin
        if (!rx_in) begin // start edge
          rx_active <= 1'b1;
          rx_bitn   <= 4'd0;
          rx_cnt    <= '0;
        end
      end else if (rx_bitn == 4'd0) begin
        if (rx_cnt == UART_HALF_LAST) begin
          rx_cnt    <= '0;
          rx_bitn   <= 4'd1;
          rx_active <= !rx_in; // glitch, back to idle
        end else begin
          rx_cnt <= rx_cnt + 1'b1;
        end
      end else if (rx_cnt == UART_BIT_LAST) begin
        rx_cnt  <= '0;
        rx_bitn <= rx_bitn + 1'b1;
        if (rx_bitn == 4'd9) begin
          rx_active  <= 1'b0;
          rx_dstrb_o <= rx_in; // drop framing errors
        end
      end else begin
        rx_cnt <= rx_cnt + 1'b1;
      end
    end
  end

  // lsb first
  always_ff @(posedge mgt_clk) begin
    if (rx_active && rx_cnt == UART_BIT_LAST && rx_bitn != 4'd0 && rx_bitn != 4'd9)
      rx_shift <= {rx_in, rx_shift[7:1]};
  end

  assign rx_data_o = rx_shift;

  always_ff @(posedge mgt_clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      tx_shift <= '1;
      tx_bits  <= 4'd0;
      tx_cnt   <= '0;
    end else if (tx_bits == 4'd0) begin
      if (tx_dstrb_i) begin
        tx_shift <= {1'b1, tx_data_i, 1'b0};
        tx_bits  <= 4'd10;
        tx_cnt   <= '0;
      end
    end else if (tx_cnt == UART_BIT_LAST) begin
      tx_cnt   <= '0;
      tx_shift <= {1'b1, tx_shift[9:1]};
      tx_bits  <= tx_bits - 1'b1;
    end else begin
      tx_cnt <= tx_cnt + 1'b1;
    end
  end

  assign tx_busy_o = tx_bits != 4'd0;
  assign serial_o  = tx_shift[0];

endmodule

// ==== hw/sys_block.sv ====
`timescale 1ns/100ps

module sys_block import wb_pkg::*, board_pkg::*; (
  input  logic                    mgt_clk,
  input  logic                    arst_n_i,
  input  logic                    wb_cyc_i,
  input  logic                    wb_stb_i,
  input  logic                    wb_we_i,
  input  wb_addr_u                wb_adr_i,
  input  logic [WB_DATA_BITS-1:0] wb_dat_i,
  output logic [WB_DATA_BITS-1:0] wb_dat_o,
  output logic                    wb_ack_o
);

  logic                    req;
  logic [WB_DATA_BITS-1:0] scratch;

  assign req = wb_cyc_i && wb_stb_i && !wb_ack_o;

  always_ff @(posedge mgt_clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wb_ack_o <= 1'b0;
      scratch  <= '0;
    end else begin
      wb_ack_o <= req;
      if (req && wb_we_i && wb_adr_i.f.offset == SYS_REG_SCRATCH)
        scratch <= wb_dat_i;
    end
  end

  always_comb begin
    case (wb_adr_i.f.offset)
      SYS_REG_ID:      wb_dat_o = BOARD_ID;
      SYS_REG_MAJOR:   wb_dat_o = REV_MAJOR;
      SYS_REG_MINOR:   wb_dat_o = REV_MINOR;
      SYS_REG_RCS:     wb_dat_o = REV_RCS;
      SYS_REG_SCRATCH: wb_dat_o = scratch;
      default:         wb_dat_o = '0;
    endcase
  end

endmodule

// ==== hw/toplevel.sv ====
`timescale 1ns/100ps

module toplevel import wb_pkg::*; (
  input  logic       mgt_clk,
  input  logic       arst_n_i,
  input  logic       serial_i,
  output logic       serial_o,
  output logic [7:0] led_n_o
);

  logic [7:0] rx_data, tx_data;
  logic       rx_dstrb, tx_dstrb, tx_busy;

  logic                    wbm_cyc, wbm_stb, wbm_we, wbm_ack, wbm_err;
  wb_addr_u                wbm_adr;
  logic [WB_DATA_BITS-1:0] wbm_wdat, wbm_rdat;

  logic [NUM_SLAVES-1:0]              wbs_cyc, wbs_stb, wbs_ack;
  logic                               wbs_we;
  wb_addr_u                           wbs_adr;
  logic [WB_DATA_BITS-1:0]            wbs_wdat;
  logic [NUM_SLAVES*WB_DATA_BITS-1:0] wbs_rdat;

  serial_uart serial_uart_inst (
    .mgt_clk(mgt_clk), .arst_n_i(arst_n_i),
    .serial_i(serial_i), .serial_o(serial_o),
    .tx_data_i(tx_data), .tx_dstrb_i(tx_dstrb), .tx_busy_o(tx_busy),
    .rx_data_o(rx_data), .rx_dstrb_o(rx_dstrb)
  );

  as_wb_bridge as_wb_bridge_inst (
    .mgt_clk(mgt_clk), .arst_n_i(arst_n_i),
    .rx_data_i(rx_data), .rx_dstrb_i(rx_dstrb), .tx_busy_i(tx_busy),
    .tx_data_o(tx_data), .tx_dstrb_o(tx_dstrb),
    .wbm_cyc_o(wbm_cyc), .wbm_stb_o(wbm_stb), .wbm_we_o(wbm_we),
    .wbm_adr_o(wbm_adr), .wbm_wdat_o(wbm_wdat),
    .wbm_rdat_i(wbm_rdat), .wbm_ack_i(wbm_ack), .wbm_err_i(wbm_err)
  );

  wbs_arbiter wbs_arbiter_inst (
    .mgt_clk(mgt_clk), .arst_n_i(arst_n_i),
    .wbm_cyc_i(wbm_cyc), .wbm_stb_i(wbm_stb), .wbm_we_i(wbm_we),
    .wbm_adr_i(wbm_adr), .wbm_wdat_i(wbm_wdat),
    .wbm_rdat_o(wbm_rdat), .wbm_ack_o(wbm_ack), .wbm_err_o(wbm_err),
    .wbs_cyc_o(wbs_cyc), .wbs_stb_o(wbs_stb), .wbs_we_o(wbs_we),
    .wbs_adr_o(wbs_adr), .wbs_wdat_o(wbs_wdat),
    .wbs_rdat_i(wbs_rdat), .wbs_ack_i(wbs_ack)
  );

  // slave 0
  sys_block sys_block_inst (
    .mgt_clk(mgt_clk), .arst_n_i(arst_n_i),
    .wb_cyc_i(wbs_cyc[0]), .wb_stb_i(wbs_stb[0]), .wb_we_i(wbs_we),
    .wb_adr_i(wbs_adr), .wb_dat_i(wbs_wdat),
    .wb_dat_o(wbs_rdat[0*WB_DATA_BITS +: WB_DATA_BITS]), .wb_ack_o(wbs_ack[0])
  );

  // slave 1
  led_block led_block_inst (
    .mgt_clk(mgt_clk), .arst_n_i(arst_n_i),
    .wb_cyc_i(wbs_cyc[1]), .wb_stb_i(wbs_stb[1]), .wb_we_i(wbs_we),
    .wb_adr_i(wbs_adr), .wb_dat_i(wbs_wdat),
    .wb_dat_o(wbs_rdat[1*WB_DATA_BITS +: WB_DATA_BITS]), .wb_ack_o(wbs_ack[1]),
    .led_n_o(led_n_o)
  );

endmodule

// ==== hw/wb_pkg.sv ====
package wb_pkg;

  localparam int WB_DATA_BITS = 16;
  localparam int WB_ADDR_BITS = 32;
  localparam int NUM_SLAVES   = 2;

  // upper address half selects the slave
  localparam logic [15:0] SYS_PAGE = 16'h0000;
  localparam logic [15:0] LED_PAGE = 16'h0001;

  typedef struct packed {
    logic [15:0] page;
    logic [15:0] offset;
  } wb_addr_s;

  // raw for byte assembly, fields for decode
  typedef union packed {
    logic [WB_ADDR_BITS-1:0] raw;
    wb_addr_s                f;
  } wb_addr_u;

endpackage

// ==== hw/wbs_arbiter.sv ====
`timescale 1ns/100ps

module wbs_arbiter import wb_pkg::*; (
  input  logic                               mgt_clk,
  input  logic                               arst_n_i,
  input  logic                               wbm_cyc_i,
  input  logic                               wbm_stb_i,
  input  logic                               wbm_we_i,
  input  wb_addr_u                           wbm_adr_i,
  input  logic [WB_DATA_BITS-1:0]            wbm_wdat_i,
  output logic [WB_DATA_BITS-1:0]            wbm_rdat_o,
  output logic                               wbm_ack_o,
  output logic                               wbm_err_o,
  output logic [NUM_SLAVES-1:0]              wbs_cyc_o,
  output logic [NUM_SLAVES-1:0]              wbs_stb_o,
  output logic                               wbs_we_o,
  output wb_addr_u                           wbs_adr_o,
  output logic [WB_DATA_BITS-1:0]            wbs_wdat_o,
  input  logic [NUM_SLAVES*WB_DATA_BITS-1:0] wbs_rdat_i,
  input  logic [NUM_SLAVES-1:0]              wbs_ack_i
);

  logic [NUM_SLAVES-1:0] sel;

  // slave index order matches the top level
  assign sel[0] = wbm_adr_i.f.page == SYS_PAGE;
  assign sel[1] = wbm_adr_i.f.page == LED_PAGE;

  assign wbs_cyc_o  = sel & {NUM_SLAVES{wbm_cyc_i}};
  assign wbs_stb_o  = sel & {NUM_SLAVES{wbm_stb_i}};
  assign wbs_we_o   = wbm_we_i;
  assign wbs_adr_o  = wbm_adr_i;
  assign wbs_wdat_o = wbm_wdat_i;

  always_comb begin
    wbm_rdat_o = '0;
    for (int i = 0; i < NUM_SLAVES; i++) begin
      if (sel[i])
        wbm_rdat_o = wbs_rdat_i[i*WB_DATA_BITS +: WB_DATA_BITS];
    end
  end

  assign wbm_ack_o = |(wbs_ack_i & sel);

  // unmapped page, single err pulse
  always_ff @(posedge mgt_clk or negedge arst_n_i) begin
    if (!arst_n_i)
      wbm_err_o <= 1'b0;
    else
      wbm_err_o <= wbm_cyc_i && wbm_stb_i && !(|sel) && !wbm_err_o;
  end

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# build and run with Verilator, result taken from sim.log
rm -rf obj_dir sim.log build.log
verilator --binary --timing --assert -Wno-fatal --top-module toplevel_tb -f flist.f \
  > build.log 2>&1 &&
  ./obj_dir/Vtoplevel_tb > sim.log 2>&1
grep -q "CHECKS FAILED" sim.log && { echo "simulation failed, see sim.log"; exit 1; }
grep -q "ALL CHECKS PASSED" sim.log || { echo "no pass result, see build.log and sim.log"; exit 1; }
echo "simulation passed"
exit 0

// ==== tb/toplevel_assert.sv ====
`timescale 1ns/100ps

module toplevel_assert (
  input logic mgt_clk,
  input logic arst_n_i,
  input logic cyc_i,
  input logic stb_i,
  input logic ack_i,
  input logic err_i
);

  stb_needs_cyc: assert property (
    @(posedge mgt_clk) disable iff (!arst_n_i) stb_i |-> cyc_i
  ) else $error("wbm_stb high while wbm_cyc is low");

  ack_err_apart: assert property (
    @(posedge mgt_clk) disable iff (!arst_n_i) !(ack_i && err_i)
  ) else $error("wbm_ack and wbm_err high together");

  // strobe held until the cycle ends
  stb_held: assert property (
    @(posedge mgt_clk) disable iff (!arst_n_i) stb_i && !ack_i && !err_i |=> stb_i
  ) else $error("wbm_stb dropped before ack or err");

endmodule

// ==== tb/toplevel_tb.sv ====
`timescale 1ns/100ps

module toplevel_tb import wb_pkg::*, board_pkg::*; ();

  typedef logic [7:0] byte_q_t [$];

  localparam int    NUM_RAND    = 4;
  localparam int    NUM_CMDS    = 13 + 4 * NUM_RAND;
  // longest exchange is 10 bytes of 10 bits each
  localparam longint WATCHDOG_NS = 2 * NUM_CMDS * 10 * 10 * UART_CLKS_PER_BIT * 10;

  logic       mgt_clk;
  logic       arst_n_i;
  logic       serial_i;
  logic       serial_o;
  logic [7:0] led_n_o;

  byte_q_t     exp_q;
  int          checked;
  logic        passed;
  logic        reported;
  logic [15:0] model_scratch;
  logic [7:0]  model_led;

  toplevel toplevel_i (
    .mgt_clk(mgt_clk), .arst_n_i(arst_n_i),
    .serial_i(serial_i), .serial_o(serial_o), .led_n_o(led_n_o)
  );

  bind wbs_arbiter toplevel_assert toplevel_assert_i (
    .mgt_clk(mgt_clk), .arst_n_i(arst_n_i),
    .cyc_i(wbm_cyc_i), .stb_i(wbm_stb_i), .ack_i(wbm_ack_o), .err_i(wbm_err_o)
  );

  initial begin
    mgt_clk = 1'b0;
    forever #5 mgt_clk = ~mgt_clk;
  end

  task automatic abort_run(input string why);
    $display("%s", why);
    reported = 1'b1;
    $display("CHECKS FAILED");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp)
      abort_run($sformatf("MISMATCH %s got 0x%0h expected 0x%0h", name, got, exp));
  endtask

  // expected response bytes and model update
  function automatic byte_q_t ref_response(
    input logic [7:0]  cmd,
    input logic [31:0] addr,
    input logic [15:0] data,
    inout logic [15:0] scratch,
    inout logic [7:0]  led
  );
    byte_q_t     rsp;
    logic [15:0] page;
    logic [15:0] offset;
    logic [15:0] rdat;
    logic        mapped;
    page   = addr[31:16];
    offset = addr[15:0];
    rdat   = 16'h0000;
    mapped = 1'b1;
    if (page == SYS_PAGE) begin
      if (cmd == CMD_WRITE && offset == SYS_REG_SCRATCH)
        scratch = data;
      if (offset == SYS_REG_ID)           rdat = BOARD_ID;
      else if (offset == SYS_REG_MAJOR)   rdat = REV_MAJOR;
      else if (offset == SYS_REG_MINOR)   rdat = REV_MINOR;
      else if (offset == SYS_REG_RCS)     rdat = REV_RCS;
      else if (offset == SYS_REG_SCRATCH) rdat = scratch;
    end else if (page == LED_PAGE) begin
      if (cmd == CMD_WRITE)
        led = data[7:0];
      rdat = {8'h00, led};
    end else begin
      mapped = 1'b0;
    end
    if (!mapped) begin
      rsp.push_back(RSP_ERR);
    end else begin
      rsp.push_back(RSP_OK);
      if (cmd == CMD_READ) begin
        rsp.push_back(rdat[15:8]);
        rsp.push_back(rdat[7:0]);
      end
    end
    return rsp;
  endfunction

  task automatic send_byte(input logic [7:0] b);
    logic [9:0] frame;
    frame = {1'b1, b, 1'b0}; // stop, data lsb first, start
    for (int i = 0; i < 10; i++) begin
      @(posedge mgt_clk);
      #1 serial_i = frame[i];
      repeat (UART_CLKS_PER_BIT - 1) @(posedge mgt_clk);
    end
  endtask

  // samples mid-bit on falling clock edges
  task automatic receive_byte(output logic [7:0] b);
    @(negedge serial_o);
    repeat (UART_CLKS_PER_BIT / 2) @(negedge mgt_clk);
    if (serial_o !== 1'b0)
      abort_run("start bit on serial_o ended too early");
    for (int i = 0; i < 8; i++) begin
      repeat (UART_CLKS_PER_BIT) @(negedge mgt_clk);
      b[i] = serial_o;
    end
    repeat (UART_CLKS_PER_BIT) @(negedge mgt_clk);
    if (serial_o !== 1'b1)
      abort_run("no stop bit on serial_o");
  endtask

  task automatic run_cmd(input logic [7:0] cmd, input logic [31:0] addr,
                         input logic [15:0] data);
    byte_q_t rsp;
    int      target;
    rsp = ref_response(cmd, addr, data, model_scratch, model_led);
    foreach (rsp[i])
      exp_q.push_back(rsp[i]);
    target = checked + rsp.size();
    send_byte(cmd);
    for (int i = 3; i >= 0; i--)
      send_byte(addr[i*8 +: 8]);
    if (cmd == CMD_WRITE) begin
      send_byte(data[15:8]);
      send_byte(data[7:0]);
    end
    wait (checked == target);
    repeat (12 * UART_CLKS_PER_BIT) @(posedge mgt_clk); // stray bytes show up in this gap
    @(negedge mgt_clk);
    check_value("led_n_o", led_n_o, 8'(~model_led));
  endtask

  initial begin : compare
    logic [7:0] got;
    wait (arst_n_i === 1'b1);
    forever begin
      receive_byte(got);
      if (exp_q.size() == 0)
        abort_run($sformatf("unexpected byte 0x%02h on serial_o", got));
      else
        check_value("serial_o byte", got, exp_q.pop_front());
      checked++;
    end
  end

  initial begin : watchdog
    #(WATCHDOG_NS);
    abort_run("timeout, the DUT did not answer all commands in time");
  end

  initial begin : stimulus
    logic [15:0] wdat;
    logic [15:0] ofs;
    void'($urandom(32'h131c));
    serial_i      = 1'b1;
    arst_n_i      = 1'b0;
    checked       = 0;
    passed        = 1'b0;
    reported      = 1'b0;
    model_scratch = 16'h0000;
    model_led     = 8'h00;
    repeat (4) @(posedge mgt_clk);
    #1 arst_n_i = 1'b1;
    @(negedge mgt_clk);
    check_value("serial_o", serial_o, 1'b1);
    check_value("led_n_o", led_n_o, 8'hff);

    for (int i = 0; i < 4; i++)
      run_cmd(CMD_READ, {SYS_PAGE, 16'(i)}, 16'h0000);
    run_cmd(CMD_READ, {SYS_PAGE, 16'h0005}, 16'h0000);
    run_cmd(CMD_READ, {SYS_PAGE, 16'h1234}, 16'h0000);

    repeat (NUM_RAND) begin
      wdat = 16'($urandom());
      run_cmd(CMD_WRITE, {SYS_PAGE, SYS_REG_SCRATCH}, wdat);
      run_cmd(CMD_READ, {SYS_PAGE, SYS_REG_SCRATCH}, 16'h0000);
    end
    run_cmd(CMD_WRITE, {SYS_PAGE, SYS_REG_ID}, 16'h5a5a); // id is read-only
    run_cmd(CMD_READ, {SYS_PAGE, SYS_REG_ID}, 16'h0000);

    repeat (NUM_RAND) begin
      wdat = 16'($urandom());
      ofs  = 16'($urandom());
      run_cmd(CMD_WRITE, {LED_PAGE, ofs}, wdat);
      run_cmd(CMD_READ, {LED_PAGE, ofs}, 16'h0000);
    end

    // unmapped page
    run_cmd(CMD_READ, {16'h0002, SYS_REG_SCRATCH}, 16'h0000);
    run_cmd(CMD_WRITE, {16'h0002, SYS_REG_SCRATCH}, 16'($urandom()));
    run_cmd(CMD_READ, {SYS_PAGE, SYS_REG_SCRATCH}, 16'h0000);
    run_cmd(CMD_READ, {LED_PAGE, 16'h0000}, 16'h0000);

    send_byte(8'h55);
    run_cmd(CMD_READ, {SYS_PAGE, SYS_REG_MINOR}, 16'h0000);

    passed = 1'b1;
    $display("ALL CHECKS PASSED");
    $finish;
  end

  // run ended by an assertion
  final begin
    if (!passed && !reported)
      $display("CHECKS FAILED");
  end

endmodule
